// File: clusterTop.f
+incdir+common
common/cfgPkg.sv
common/clbPkg.sv
design/lut4cDffesr.sv
design/logicCluster.sv
configPort/apbConfigPort.sv
design/clusterTop.sv
test/clockGen.sv
test/tbClusterTop.sv

// File: common/cfgPkg.sv
`default_nettype none

`include "fabric_consts.svh"

package cfgPkg;

	// Master to slave, one bundle per transfer
	typedef struct packed {
		logic psel; // Slave selected
		logic penable; // High in access phase
		logic pwrite; // 1 write, 0 read
		logic [`APB_ADDR_W-1:0] paddr; // Word address, no byte lanes
		logic [31:0] pwdata; // Write data
	} apbReqT;

	// Slave to master
	typedef struct packed {
		logic [31:0] prdata; // Read data, valid in access phase
		logic pready; // Tied high, zero wait states
		logic pslverr; // Unmapped address
	} apbRspT;

	// Register selected by paddr
	typedef enum logic [1:0] {
		regCell, // Cell configuration word 0..NUM_CELLS-1
		regCtrl, // Control, bit 0 enable mask
		regId, // Read-only cell count
		regBad // Anything else
	} regOpE;

endpackage

`default_nettype wire

// File: common/clbPkg.sv
`default_nettype none

`include "fabric_consts.svh"

package clbPkg;

	// One cell configuration, CFG_BITS wide
	// Bit 18 resetValue, 17 i0Carry, 16 outFlop, 15:0 truthTable
	typedef struct packed {
		logic resetValue; // Loaded into flop while sr is high
		logic i0Carry; // LUT index bit 0 from carry-in instead of I0
		logic outFlop; // Output from flop instead of LUT
		logic [(2**`LUT_SIZE)-1:0] truthTable; // Indexed by {I3, I2, I1, I0mux}
	} lutCfgT;

	// Flop controls shared by every cell of the cluster
	typedef struct packed {
		logic en; // Clock enable
		logic sr; // Synchronous set/reset
	} cellCtrlT;

	// Keeps the struct in step with the register map
	localparam int LUT_CFG_W = $bits(lutCfgT);

	// Control word width, matches cellCtrlT
	localparam int CELL_CTRL_W = $bits(cellCtrlT);

endpackage

`default_nettype wire

// File: common/fabric_consts.svh
`ifndef FABRIC_CONSTS_SVH
`define FABRIC_CONSTS_SVH

// Cluster geometry
`define NUM_CELLS 8 // LUT cells per cluster, one carry chain
`define LUT_SIZE 4 // Inputs per LUT

// Per-cell configuration word
// Truth table 16, output select, I0 carry select, set/reset value
`define CFG_BITS 19

// APB word address width
// Cells at 0..7, control at 8, identifier at 9
`define APB_ADDR_W 6

`endif

// File: configPort/apbConfigPort.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_consts.svh"

// APB slave for the cluster configuration
// Zero wait states, so no FSM; setup then access, two cycles per transfer
module apbConfigPort
	import cfgPkg::*;
	import clbPkg::*;
(
	input wire logic UserCLK,
	input wire logic rstN,
	input wire apbReqT apbReq,
	output apbRspT apbRsp,
	input wire logic extEn, // External flop enable
	input wire logic extSr, // External set/reset
	output lutCfgT [`NUM_CELLS-1:0] cfg, // Configuration words to the cells
	output cellCtrlT ctrl // Gated flop controls
);

	localparam int IDX_W = $clog2(`NUM_CELLS); // Cell select bits of paddr
	localparam int PAD_W = 32 - `CFG_BITS; // Zero fill on cell read-back

	lutCfgT [`NUM_CELLS-1:0] cfgQ; // Cell configuration store
	logic enMaskQ; // Control bit 0
	logic [31:0] prdataQ; // Registered read data

	regOpE regOp; // Decoded register
	logic [IDX_W-1:0] cellIdx; // Cell word select
	logic setupPh; // First cycle of a transfer
	logic accessPh; // Second cycle, write commits at its end
	logic [31:0] rdData; // Read mux

	assign setupPh = apbReq.psel & ~apbReq.penable;
	assign accessPh = apbReq.psel & apbReq.penable;
	assign cellIdx = apbReq.paddr[IDX_W-1:0];

	// Address decode, paddr is a word address
	always_comb begin
		if (apbReq.paddr < `APB_ADDR_W'(`NUM_CELLS)) begin
			regOp = regCell;
		end else if (apbReq.paddr == `APB_ADDR_W'(`NUM_CELLS)) begin
			regOp = regCtrl; // Address 8
		end else if (apbReq.paddr == `APB_ADDR_W'(`NUM_CELLS + 1)) begin
			regOp = regId; // Address 9
		end else begin
			regOp = regBad;
		end
	end

	// Read mux, unmapped reads return zero
	always_comb begin
		unique case (regOp)
			regCell: rdData = {{PAD_W{1'b0}}, cfgQ[cellIdx]};
			regCtrl: rdData = {31'b0, enMaskQ};
			regId: rdData = 32'(`NUM_CELLS); // Cell count
			default: rdData = '0;
		endcase
	end

	// Configuration and control writes, taken at the end of the access phase
	always_ff @(posedge UserCLK or negedge rstN) begin
		if (!rstN) begin
			cfgQ <= '0; // All truth tables zero
			enMaskQ <= 1'b0; // Flops frozen until software enables
		end else if (accessPh && apbReq.pwrite) begin
			unique case (regOp)
				regCell: cfgQ[cellIdx] <= lutCfgT'(apbReq.pwdata[`CFG_BITS-1:0]);
				regCtrl: enMaskQ <= apbReq.pwdata[0];
				default: ; // Identifier is read-only, bad address ignored
			endcase
		end
	end

	// Read data captured at the setup edge, so it is stable through access
	always_ff @(posedge UserCLK or negedge rstN) begin
		if (!rstN) begin
			prdataQ <= '0;
		end else if (setupPh && !apbReq.pwrite) begin
			prdataQ <= rdData;
		end
	end

	// Response, error flagged only during the access phase
	assign apbRsp = '{
		prdata: prdataQ,
		pready: 1'b1, // Never stalls
		pslverr: accessPh & (regOp == regBad)
	};

	assign cfg = cfgQ;

	// Mask gates the external enable, sr passes through
	assign ctrl = '{en: enMaskQ & extEn, sr: extSr};

endmodule

`default_nettype wire

// File: design/clusterTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_consts.svh"

// Cluster top, APB configuration port plus the logic cluster
module clusterTop
	import cfgPkg::*;
	import clbPkg::*;
(
	input wire logic UserCLK,
	input wire logic rstN,
	input wire apbReqT apbReq, // From the APB master
	output apbRspT apbRsp,
	input wire logic extEn, // Fabric enable pin
	input wire logic extSr, // Fabric set/reset pin
	input wire logic [`NUM_CELLS*`LUT_SIZE-1:0] fabricIn,
	input wire logic carryIn,
	output logic [`NUM_CELLS-1:0] fabricOut,
	output logic carryOut
);

	lutCfgT [`NUM_CELLS-1:0] cellCfg; // Port to cluster configuration
	cellCtrlT cellCtrl; // Gated en and sr

	// Register file and control
	apbConfigPort uCfgPort (
		.UserCLK (UserCLK),
		.rstN (rstN),
		.apbReq (apbReq),
		.apbRsp (apbRsp),
		.extEn (extEn),
		.extSr (extSr),
		.cfg (cellCfg),
		.ctrl (cellCtrl)
	);

	// LUT cells and carry chain
	logicCluster uCluster (
		.UserCLK (UserCLK),
		.rstN (rstN),
		.cfg (cellCfg),
		.ctrl (cellCtrl),
		.fabricIn (fabricIn),
		.carryIn (carryIn),
		.fabricOut (fabricOut),
		.carryOut (carryOut)
	);

endmodule

`default_nettype wire

// File: design/logicCluster.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_consts.svh"

// Eight LUT cells on one ripple carry chain
module logicCluster
	import clbPkg::*;
(
	input wire logic UserCLK,
	input wire logic rstN,
	input wire lutCfgT [`NUM_CELLS-1:0] cfg, // One word per cell
	input wire cellCtrlT ctrl, // Shared by all cells
	input wire logic [`NUM_CELLS*`LUT_SIZE-1:0] fabricIn, // Cell k takes slice k
	input wire logic carryIn, // Into cell 0
	output logic [`NUM_CELLS-1:0] fabricOut, // Bit k from cell k
	output logic carryOut // Out of the last cell
);

	// Carry between cells, index k feeds cell k
	logic [`NUM_CELLS:0] carry;

	assign carry[0] = carryIn;

	for (genvar k = 0; k < `NUM_CELLS; k++) begin : gCell
		lut4cDffesr uCell (
			.UserCLK (UserCLK),
			.rstN (rstN),
			.cfg (cfg[k]),
			.ctrl (ctrl),
			.lutIn (fabricIn[k*`LUT_SIZE +: `LUT_SIZE]), // 4-bit slice k
			.ci (carry[k]),
			.o (fabricOut[k]),
			.co (carry[k+1]) // Ripples to the next cell
		);
	end

	assign carryOut = carry[`NUM_CELLS];

endmodule

`default_nettype wire

// File: design/lut4cDffesr.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_consts.svh"

// One LUT4 cell with carry and an enabled set/reset flop
module lut4cDffesr
	import clbPkg::*;
(
	input wire logic UserCLK,
	input wire logic rstN, // Async clear of the flop
	input wire lutCfgT cfg, // Static configuration
	input wire cellCtrlT ctrl, // Shared en and sr
	input wire logic [`LUT_SIZE-1:0] lutIn, // I3..I0
	input wire logic ci, // Carry in
	output logic o, // Cell output
	output logic co // Carry out
);

	logic i0Mux; // I0 or carry-in
	logic [`LUT_SIZE-1:0] lutIdx; // Truth table index
	logic lutOut; // Combinational LUT result
	logic lutFlop; // Registered LUT result

	// I0 replaced by the incoming carry when configured
	assign i0Mux = cfg.i0Carry ? ci : lutIn[0];

	assign lutIdx = {lutIn[`LUT_SIZE-1:1], i0Mux};

	// LUT is a 16:1 mux over the truth table
	assign lutOut = cfg.truthTable[lutIdx];

	// Output select, flop or straight LUT
	assign o = cfg.outFlop ? lutFlop : lutOut;

	// iCE40 style carry, majority of ci, I1 and I2
	assign co = (ci & lutIn[1]) | (ci & lutIn[2]) | (lutIn[1] & lutIn[2]);

	// Flop: async clear, then sync load under en
	always_ff @(posedge UserCLK or negedge rstN) begin
		if (!rstN) begin
			lutFlop <= 1'b0;
		end else if (ctrl.en) begin
			if (ctrl.sr) begin
				lutFlop <= cfg.resetValue; // sr wins over data
			end else begin
				lutFlop <= lutOut;
			end
		end
	end

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Builds the cluster testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/VtbClusterTop

verilator --binary --assert --timing \
	-f clusterTop.f \
	--top-module tbClusterTop
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$BIN" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
fi

if grep -qx '>>> PASS' "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: test/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench clock and power-on reset
module clockGen #(
	parameter int HALF_PERIOD = 10, // 20 ns period
	parameter int RESET_CYCLES = 5
) (
	output logic UserCLK,
	output logic rstN
);

	initial begin
		UserCLK = 1'b0;
		forever #(HALF_PERIOD) UserCLK = ~UserCLK;
	end

	// Reset released on a falling edge, away from the flops
	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge UserCLK);
		@(negedge UserCLK);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

// File: test/cluster_cases.txt
# W addr data | R addr expData expErr | C expOut (async clear) | A count (random)
# V extEn extSr fabricIn carryIn expOut expCarry clocks, every field hex
# Reset state
R 0 0 0
R 1 0 0
R 2 0 0
R 3 0 0
R 4 0 0
R 5 0 0
R 6 0 0
R 7 0 0
R 8 0 0
V 0 0 ffffffff 1 00 1 0
# Identifier, unmapped addresses, read-back of the low 19 bits
R 9 8 0
R a 0 1
R 3f 0 1
W a 12345
W 0 fffff5a5
R 0 7f5a5 0
R 2 0 0
# Combinational truth tables: AND4 OR4 XOR4 ~I3 I0 I1 I2 and a mixed one
W 0 8000
W 1 fffe
W 2 6996
W 3 00ff
W 4 aaaa
W 5 cccc
W 6 f0f0
W 7 1234
R 7 1234 0
V 0 0 8465970f 0 75 0 0
V 0 0 00000000 1 08 0 0
# I0 of cell 4 from the carry
W 4 2aaaa
R 4 2aaaa 0
V 0 0 00006666 0 1a 0 0
V 0 0 00010000 0 08 0 0
A 20
# Registered cells 0 (reset value 1) and 2 (reset value 0)
W 0 58000
W 2 16996
V 0 0 8465970f 0 60 0 0
V 1 0 8465970f 0 60 0 1
V 0 0 8465970f 0 60 0 0
W 8 1
R 8 1 0
V 1 0 8465970f 0 65 0 1
V 0 0 00000000 0 0d 0 1
W 8 0
V 1 0 00000000 0 0d 0 2
V 0 0 00000000 0 0d 0 0
W 8 1
V 1 1 00000000 0 09 0 1
V 1 0 00000000 0 08 0 1
V 1 0 8465970f 0 65 0 1
# Async clear mid-run
C 00
R 0 0 0
R 2 0 0
R 8 0 0
V 0 0 ffffffff 1 00 1 0

// File: test/tbClusterTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_consts.svh"

// Testbench for clusterTop with APB and fabric stimulus from the case file
module tbClusterTop
	import cfgPkg::*;
	import clbPkg::*;
();

	localparam string CASE_FILE = "test/cluster_cases.txt";
	localparam int SETTLE = 5; // Sample point after a falling edge
	localparam int SEL_W = $clog2(`NUM_CELLS);

	logic UserCLK;
	logic genRstN; // Power-on reset
	logic clrN; // Mid-run async clear
	logic rstN;
	apbReqT apbReq;
	apbRspT apbRsp;
	logic extEn;
	logic extSr;
	logic [`NUM_CELLS*`LUT_SIZE-1:0] fabricIn;
	logic carryIn;
	logic [`NUM_CELLS-1:0] fabricOut;
	logic carryOut;

	lutCfgT cfgModel [`NUM_CELLS]; // Expected cell configuration
	int wdCycles; // Zero until the cases are counted
	int caseNum; // Record being run

	assign rstN = genRstN & clrN;

	clockGen uClk (
		.UserCLK (UserCLK),
		.rstN (genRstN)
	);

	clusterTop u_dut (
		.UserCLK (UserCLK),
		.rstN (rstN),
		.apbReq (apbReq),
		.apbRsp (apbRsp),
		.extEn (extEn),
		.extSr (extSr),
		.fabricIn (fabricIn),
		.carryIn (carryIn),
		.fabricOut (fabricOut),
		.carryOut (carryOut)
	);

	task automatic stopRun(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "Run stopped");
	endtask

	task automatic failNow(input string msg);
		stopRun($sformatf("Fail at %0t ns: case %0d, %s", $time, caseNum, msg));
	endtask

	task automatic skipLine(input int fd);
		int ch;
		ch = $fgetc(fd);
		while (ch != 10 && ch != -1) begin
			ch = $fgetc(fd);
		end
	endtask

	// One case per record and one per random vector
	task automatic countCases(output int count);
		int fd;
		logic [7:0] tok;
		logic [31:0] num;
		count = 0;
		fd = $fopen(CASE_FILE, "r");
		if (fd != 0) begin
			while ($fscanf(fd, " %c", tok) == 1) begin
				if (tok == "A" && $fscanf(fd, "%h", num) == 1) begin
					count = count + int'(num);
				end else begin
					if (tok != "#") count++;
					skipLine(fd);
				end
			end
			$fclose(fd);
		end
	endtask

	// LUT and majority-carry rules give {carryOut, fabricOut}
	function automatic logic [`NUM_CELLS:0] clusterModel(
		input logic [`NUM_CELLS*`LUT_SIZE-1:0] fin,
		input logic cin
	);
		logic c;
		logic [`LUT_SIZE-1:0] s;
		logic [`LUT_SIZE-1:0] idx;
		logic [`NUM_CELLS-1:0] outs;
		c = cin;
		outs = '0;
		for (int k = 0; k < `NUM_CELLS; k++) begin
			s = fin[k*`LUT_SIZE +: `LUT_SIZE];
			idx = {s[3:1], (cfgModel[k].i0Carry ? c : s[0])};
			outs[k] = cfgModel[k].truthTable[idx];
			c = (int'(c) + int'(s[1]) + int'(s[2])) >= 2; // At least two of three set
		end
		return {c, outs};
	endfunction

	task automatic apbWrite(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data);
		@(negedge UserCLK);
		apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(negedge UserCLK);
		apbReq.penable = 1'b1; // Commits at the next rising edge
		@(negedge UserCLK);
		apbReq = '0;
		if (addr < `APB_ADDR_W'(`NUM_CELLS)) begin
			cfgModel[addr[SEL_W-1:0]] = lutCfgT'(data[`CFG_BITS-1:0]); // Low 19 bits kept
		end
	endtask

	task automatic apbRead(
		input logic [`APB_ADDR_W-1:0] addr,
		input logic [31:0] expData,
		input logic expErr
	);
		@(negedge UserCLK);
		apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
		@(negedge UserCLK);
		apbReq.penable = 1'b1;
		#(SETTLE); // Response valid in the access phase
		assert (apbRsp.prdata === expData && apbRsp.pslverr === expErr && apbRsp.pready === 1'b1)
		else failNow($sformatf("read %h gave %h err %b, expected %h err %b",
			addr, apbRsp.prdata, apbRsp.pslverr, expData, expErr));
		@(negedge UserCLK);
		apbReq = '0;
	endtask

	task automatic applyVector(
		input logic en,
		input logic sr,
		input logic [`NUM_CELLS*`LUT_SIZE-1:0] fin,
		input logic cin,
		input logic [`NUM_CELLS-1:0] expOut,
		input logic expCarry,
		input int clocks
	);
		@(negedge UserCLK);
		extEn = en;
		extSr = sr;
		fabricIn = fin;
		carryIn = cin;
		repeat (clocks) @(negedge UserCLK);
		#(SETTLE);
		assert (fabricOut === expOut && carryOut === expCarry)
		else failNow($sformatf("fabricOut %h carryOut %b, expected %h %b",
			fabricOut, carryOut, expOut, expCarry));
	endtask

	// Filler vectors with registered cells masked out
	task automatic randomVectors(input int count);
		logic [31:0] rnd;
		logic [`NUM_CELLS:0] expVal;
		logic [`NUM_CELLS-1:0] mask;
		for (int i = 0; i < count; i++) begin
			@(negedge UserCLK);
			rnd = $urandom;
			fabricIn = $urandom;
			carryIn = rnd[0];
			extEn = 1'b0;
			extSr = 1'b0;
			#(SETTLE);
			expVal = clusterModel(fabricIn, carryIn);
			for (int k = 0; k < `NUM_CELLS; k++) begin
				mask[k] = ~cfgModel[k].outFlop;
			end
			assert (((fabricOut ^ expVal[`NUM_CELLS-1:0]) & mask) == '0
				&& carryOut === expVal[`NUM_CELLS])
			else failNow($sformatf("random in %h ci %b gave %h %b, expected %h %b",
				fabricIn, carryIn, fabricOut, carryOut,
				expVal[`NUM_CELLS-1:0], expVal[`NUM_CELLS]));
		end
	endtask

	// rstN dropped between edges clears the outputs in the same step
	task automatic asyncClear(input logic [`NUM_CELLS-1:0] expOut);
		lutCfgT flopOnly; // Output from the flop, zero truth table
		flopOnly = '0;
		flopOnly.outFlop = 1'b1;
		@(negedge UserCLK);
		clrN = 1'b0;
		#1;
		assert (fabricOut === expOut)
		else failNow($sformatf("fabricOut %h under clear, expected %h", fabricOut, expOut));
		for (int k = 0; k < `NUM_CELLS; k++) begin
			cfgModel[k] = '0;
		end
		@(negedge UserCLK);
		clrN = 1'b1;
		// Mask is zero after the clear and the flops hold their cleared value
		for (int k = 0; k < `NUM_CELLS; k++) begin
			apbWrite(`APB_ADDR_W'(k), 32'(flopOnly));
		end
		#(SETTLE);
		assert (fabricOut === '0)
		else failNow($sformatf("fabricOut %h from the flops after clear, expected 0",
			fabricOut));
		for (int k = 0; k < `NUM_CELLS; k++) begin
			apbWrite(`APB_ADDR_W'(k), 32'h0); // Back to the cleared configuration
		end
	endtask

	initial begin
		int fd;
		int caseCount;
		logic [7:0] tok;
		logic [31:0] fld [7];
		apbReq = '0;
		extEn = 1'b0;
		extSr = 1'b0;
		fabricIn = '0;
		carryIn = 1'b0;
		clrN = 1'b1;
		caseNum = 0;
		for (int k = 0; k < `NUM_CELLS; k++) begin
			cfgModel[k] = '0;
		end
		void'($urandom(32'heccb_b2c3));
		countCases(caseCount);
		wdCycles = caseCount * 10 + 200;
		wait (genRstN === 1'b1);
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			stopRun({"Cannot open the case file ", CASE_FILE});
		end else begin
			while ($fscanf(fd, " %c", tok) == 1) begin
				if (tok != "#") caseNum++;
				case (tok)
					"#": skipLine(fd); // Comment
					"W": if ($fscanf(fd, "%h %h", fld[0], fld[1]) != 2)
						stopRun("Malformed write record in the case file");
					else
						apbWrite(fld[0][`APB_ADDR_W-1:0], fld[1]);
					"R": if ($fscanf(fd, "%h %h %h", fld[0], fld[1], fld[2]) != 3)
						stopRun("Malformed read record in the case file");
					else
						apbRead(fld[0][`APB_ADDR_W-1:0], fld[1], fld[2][0]);
					"V": if ($fscanf(fd, "%h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
						fld[3], fld[4], fld[5], fld[6]) != 7)
						stopRun("Malformed vector record in the case file");
					else
						applyVector(fld[0][0], fld[1][0], fld[2], fld[3][0],
							fld[4][`NUM_CELLS-1:0], fld[5][0], int'(fld[6]));
					"A": if ($fscanf(fd, "%h", fld[0]) != 1)
						stopRun("Malformed random record in the case file");
					else
						randomVectors(int'(fld[0]));
					"C": if ($fscanf(fd, "%h", fld[0]) != 1)
						stopRun("Malformed clear record in the case file");
					else
						asyncClear(fld[0][`NUM_CELLS-1:0]);
					default: stopRun($sformatf("Unknown record type %c in the case file", tok));
				endcase
			end
			$fclose(fd);
			$display(">>> PASS");
			$finish;
		end
	end

	// Watchdog with a budget from the case count
	initial begin
		wait (wdCycles != 0);
		repeat (wdCycles) @(posedge UserCLK);
		stopRun($sformatf("Timeout, the cases did not finish within %0d cycles", wdCycles));
	end

endmodule

`default_nettype wire
